//--- logic/dma_macros.svh
/* DMA copy engine widths and depths.
   Shared by the package and the buffer modules. */

`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// ****************************************
// Datapath widths
// ****************************************
`define DMA_DATA_W 64     // One full word per beat.
`define DMA_ADDR_W 32     // Word address.
`define DMA_LEN_W  8      // Beats minus one, as on AXI.

// ****************************************
// Buffer depths
// ****************************************
`define DMA_DESC_DEPTH 4  // Pending descriptors.
`define DMA_DATA_DEPTH 8  // Buffered beats between read and write.

`endif

//--- logic/dma_pkg.sv
/* DMA copy engine types.
   Vector typedefs for the datapath and the read and write FSM states. */

`default_nettype none

`include "dma_macros.svh"

package dma_pkg;

   typedef logic [`DMA_DATA_W-1:0] t_dma_data;
   typedef logic [`DMA_ADDR_W-1:0] t_dma_addr;
   typedef logic [`DMA_LEN_W-1:0]  t_dma_len;   // Beats minus one.

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR_SETUP,
      RD_COPY_BEATS,
      RD_WAIT_WR_DONE
   } t_rd_state;

   typedef enum logic [2:0] {
      WR_IDLE,
      WR_ADDR_SETUP,
      WR_SEND_BEATS,
      WR_WAIT_RESP,
      WR_DONE
   } t_wr_state;

endpackage

`default_nettype wire

//--- logic/dma_descriptor_fifo.sv
/* Descriptor queue of pending copies.
   Presents the oldest descriptor at its head until it is popped. */

`timescale 1ns/1ps
`default_nettype none

`include "dma_macros.svh"

module dma_descriptor_fifo
   import dma_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  logic      push_valid,
   output logic      push_ready,
   input  t_dma_addr push_src_addr,
   input  t_dma_addr push_dst_addr,
   input  t_dma_len  push_len,
   output logic      head_valid,
   output t_dma_addr head_src_addr,
   output t_dma_addr head_dst_addr,
   output t_dma_len  head_len,
   input  logic      pop
);

   localparam int PTR_W = $clog2(`DMA_DESC_DEPTH);
   localparam int CNT_W = $clog2(`DMA_DESC_DEPTH + 1);

   t_dma_addr        src_mem [`DMA_DESC_DEPTH];
   t_dma_addr        dst_mem [`DMA_DESC_DEPTH];
   t_dma_len         len_mem [`DMA_DESC_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign push_ready    = (count != CNT_W'(`DMA_DESC_DEPTH));
   assign head_valid    = (count != '0);
   assign head_src_addr = src_mem[rd_ptr];
   assign head_dst_addr = dst_mem[rd_ptr];
   assign head_len      = len_mem[rd_ptr];

   assign do_push = push_valid && push_ready;
   assign do_pop  = pop && head_valid;

   always_ff @(posedge clk) begin
      if (do_push) begin
         src_mem[wr_ptr] <= push_src_addr;
         dst_mem[wr_ptr] <= push_dst_addr;
         len_mem[wr_ptr] <= push_len;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`DMA_DESC_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`DMA_DESC_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(do_push) - CNT_W'(do_pop);  // Both may happen at once.
      end
   end

endmodule

`default_nettype wire

//--- logic/dma_read_fsm.sv
/* Source read FSM.
   Issues the read burst for the head descriptor and forwards beats into the data FIFO. */

`timescale 1ns/1ps
`default_nettype none

module dma_read_fsm
   import dma_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  logic      head_valid,
   input  t_dma_addr head_src_addr,
   input  t_dma_len  head_len,
   output logic      pop,
   output logic      ar_valid,
   input  logic      ar_ready,
   output t_dma_addr ar_addr,
   output t_dma_len  ar_len,
   input  logic      r_valid,
   output logic      r_ready,
   input  t_dma_data r_data,
   input  logic      r_last,
   output logic      beat_valid,
   input  logic      beat_ready,
   output t_dma_data beat_data,
   input  logic      wr_done
);

   t_rd_state state;
   logic      copying;

   assign copying = (state == RD_COPY_BEATS);

   // Beats pass straight through, so a full data FIFO stalls the read data channel.
   assign r_ready    = copying && beat_ready;
   assign beat_valid = copying && r_valid;
   assign beat_data  = r_data;

   // The descriptor leaves the queue only once the write side has its response.
   assign pop = (state == RD_WAIT_WR_DONE) && wr_done;

   // Address payload is captured as the FSM leaves IDLE.
   always_ff @(posedge clk) begin
      if (state == RD_IDLE && head_valid) begin
         ar_addr <= head_src_addr;
         ar_len  <= head_len;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= RD_IDLE;
         ar_valid <= 1'b0;
      end else begin
         case (state)
            RD_IDLE: begin
               if (head_valid) begin
                  state <= RD_ADDR_SETUP;
               end
            end
            RD_ADDR_SETUP: begin
               if (!ar_valid) begin
                  ar_valid <= 1'b1;                // Rises one cycle after entry.
               end else if (ar_ready) begin
                  ar_valid <= 1'b0;
                  state    <= RD_COPY_BEATS;
               end
            end
            RD_COPY_BEATS: begin
               if (r_valid && r_ready && r_last) begin
                  state <= RD_WAIT_WR_DONE;
               end
            end
            RD_WAIT_WR_DONE: begin
               if (wr_done) begin
                  state <= RD_IDLE;
               end
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/dma_data_fifo.sv
/* Beat buffer between the read and write sides.
   Lets the source read rate differ from the destination write rate. */

`timescale 1ns/1ps
`default_nettype none

`include "dma_macros.svh"

module dma_data_fifo
   import dma_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  logic      in_valid,
   output logic      in_ready,
   input  t_dma_data in_data,
   output logic      out_valid,
   input  logic      out_ready,
   output t_dma_data out_data
);

   localparam int PTR_W = $clog2(`DMA_DATA_DEPTH);
   localparam int CNT_W = $clog2(`DMA_DATA_DEPTH + 1);

   t_dma_data        mem [`DMA_DATA_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_write;
   logic             do_read;

   assign in_ready  = (count != CNT_W'(`DMA_DATA_DEPTH));  // Not full.
   assign out_valid = (count != '0);                      // Not empty.
   assign out_data  = mem[rd_ptr];

   assign do_write = in_valid && in_ready;
   assign do_read  = out_valid && out_ready;

   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= in_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= (wr_ptr == PTR_W'(`DMA_DATA_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= (rd_ptr == PTR_W'(`DMA_DATA_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(do_write) - CNT_W'(do_read);
      end
   end

endmodule

`default_nettype wire

//--- logic/dma_write_fsm.sv
/* Destination write FSM.
   Issues the write burst, drains the data FIFO and reports completion after the response. */

`timescale 1ns/1ps
`default_nettype none

module dma_write_fsm
   import dma_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  logic      head_valid,
   input  t_dma_addr head_dst_addr,
   input  t_dma_len  head_len,
   output logic      aw_valid,
   input  logic      aw_ready,
   output t_dma_addr aw_addr,
   output t_dma_len  aw_len,
   output logic      w_valid,
   input  logic      w_ready,
   output t_dma_data w_data,
   output logic      w_last,
   input  logic      beat_valid,
   output logic      beat_ready,
   input  t_dma_data beat_data,
   input  logic      b_valid,
   output logic      b_ready,
   output logic      wr_done
);

   t_wr_state state;
   t_dma_len  beat_cnt;
   logic      sending;

   assign sending    = (state == WR_SEND_BEATS);
   assign w_valid    = sending && beat_valid;
   assign beat_ready = sending && w_ready;
   assign w_data     = beat_data;
   assign w_last     = (beat_cnt == head_len);
   assign b_ready    = (state == WR_WAIT_RESP);
   assign wr_done    = (state == WR_DONE);        // Head is popped at this edge.

   always_ff @(posedge clk) begin
      if (state == WR_IDLE && head_valid) begin
         aw_addr <= head_dst_addr;
         aw_len  <= head_len;
      end
   end

   // DONE lasts one cycle and the pop lands on its edge, so IDLE always sees a fresh head.
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state    <= WR_IDLE;
         aw_valid <= 1'b0;
         beat_cnt <= '0;
      end else begin
         case (state)
            WR_IDLE: begin
               if (head_valid) begin
                  state <= WR_ADDR_SETUP;
               end
            end
            WR_ADDR_SETUP: begin
               if (!aw_valid) begin
                  aw_valid <= 1'b1;
               end else if (aw_ready) begin
                  aw_valid <= 1'b0;
                  beat_cnt <= '0;
                  state    <= WR_SEND_BEATS;
               end
            end
            WR_SEND_BEATS: begin
               if (w_valid && w_ready) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (w_last) begin
                     state <= WR_WAIT_RESP;
                  end
               end
            end
            WR_WAIT_RESP: begin
               if (b_valid) begin
                  state <= WR_DONE;
               end
            end
            default: state <= WR_IDLE;         // WR_DONE returns here after one cycle.
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/dma_engine.sv
/* Descriptor-driven DMA copy engine.
   Copies word bursts from a read port to a write port, one descriptor at a time. */

`timescale 1ns/1ps
`default_nettype none

module dma_engine
   import dma_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  logic      desc_valid,
   output logic      desc_ready,
   input  t_dma_addr desc_src_addr,
   input  t_dma_addr desc_dst_addr,
   input  t_dma_len  desc_len,
   output logic      ar_valid,
   input  logic      ar_ready,
   output t_dma_addr ar_addr,
   output t_dma_len  ar_len,
   input  logic      r_valid,
   output logic      r_ready,
   input  t_dma_data r_data,
   input  logic      r_last,
   output logic      aw_valid,
   input  logic      aw_ready,
   output t_dma_addr aw_addr,
   output t_dma_len  aw_len,
   output logic      w_valid,
   input  logic      w_ready,
   output t_dma_data w_data,
   output logic      w_last,
   input  logic      b_valid,
   output logic      b_ready,
   output logic      done
);

   logic      head_valid;
   t_dma_addr head_src_addr;
   t_dma_addr head_dst_addr;
   t_dma_len  head_len;
   logic      pop;
   logic      in_valid;
   logic      in_ready;
   t_dma_data in_data;
   logic      out_valid;
   logic      out_ready;
   t_dma_data out_data;
   logic      wr_done;

   assign done = wr_done;

   dma_descriptor_fifo dma_descriptor_fifo_inst (
      .clk(clk), .reset_n(reset_n),
      .push_valid(desc_valid), .push_ready(desc_ready),
      .push_src_addr(desc_src_addr), .push_dst_addr(desc_dst_addr), .push_len(desc_len),
      .head_valid(head_valid), .head_src_addr(head_src_addr),
      .head_dst_addr(head_dst_addr), .head_len(head_len), .pop(pop)
   );

   dma_read_fsm dma_read_fsm_inst (
      .clk(clk), .reset_n(reset_n),
      .head_valid(head_valid), .head_src_addr(head_src_addr), .head_len(head_len),
      .pop(pop), .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
      .ar_len(ar_len), .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data),
      .r_last(r_last), .beat_valid(in_valid), .beat_ready(in_ready),
      .beat_data(in_data), .wr_done(wr_done)
   );

   dma_data_fifo dma_data_fifo_inst (
      .clk(clk), .reset_n(reset_n),
      .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
      .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
   );

   dma_write_fsm dma_write_fsm_inst (
      .clk(clk), .reset_n(reset_n),
      .head_valid(head_valid), .head_dst_addr(head_dst_addr), .head_len(head_len),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr), .aw_len(aw_len),
      .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_last(w_last),
      .beat_valid(out_valid), .beat_ready(out_ready), .beat_data(out_data),
      .b_valid(b_valid), .b_ready(b_ready), .wr_done(wr_done)
   );

endmodule

`default_nettype wire

//--- verification/dma_engine_tb.sv
/* DMA copy engine testbench.
   Random descriptors against read and write memory models and a descriptor queue model. */

`timescale 1ns/1ps
`default_nettype none

module dma_engine_tb
   import dma_pkg::*;
;

   localparam int NUM_DESC   = 24;
   localparam int WAIT_LIMIT = 2000;   // Cycles allowed for any single wait.

   logic      clk;
   logic      reset_n;
   logic      desc_valid;
   logic      desc_ready;
   t_dma_addr desc_src_addr;
   t_dma_addr desc_dst_addr;
   t_dma_len  desc_len;
   logic      ar_valid;
   logic      ar_ready;
   t_dma_addr ar_addr;
   t_dma_len  ar_len;
   logic      r_valid;
   logic      r_ready;
   t_dma_data r_data;
   logic      r_last;
   logic      aw_valid;
   logic      aw_ready;
   t_dma_addr aw_addr;
   t_dma_len  aw_len;
   logic      w_valid;
   logic      w_ready;
   t_dma_data w_data;
   logic      w_last;
   logic      b_valid;
   logic      b_ready;
   logic      done;

   integer    seed;
   t_dma_addr exp_src[$];               // Descriptors in push order.
   t_dma_addr exp_dst[$];
   t_dma_len  exp_len[$];
   int        b_count;
   int        done_count;
   logic      saw_full;

   dma_engine dma_engine_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ****************************************
   // Failure reporting and compare tasks
   // ****************************************
   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_addr(input string name, input t_dma_addr exp, input t_dma_addr act);
      if (act !== exp) begin
         $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
         report_failure("address compare failed");
      end
   endtask

   task automatic check_len(input string name, input t_dma_len exp, input t_dma_len act);
      if (act !== exp) begin
         $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
         report_failure("length compare failed");
      end
   endtask

   task automatic check_data(input string name, input t_dma_data exp, input t_dma_data act);
      if (act !== exp) begin
         $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
         report_failure("data compare failed");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("mismatch %s: expected %0b, actual %0b", name, exp, act);
         report_failure("control signal compare failed");
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
         report_failure("count compare failed");
      end
   endtask

   // Source memory content is the address followed by its inverse.
   function automatic t_dma_data source_word(input t_dma_addr a);
      return {a, ~a};
   endfunction

   task automatic push_descriptor(input t_dma_addr src, input t_dma_addr dst,
                                  input t_dma_len len);
      int waited;
      waited        = 0;
      desc_valid    = 1'b1;
      desc_src_addr = src;
      desc_dst_addr = dst;
      desc_len      = len;
      @(posedge clk);
      while (!desc_ready) begin
         saw_full = 1'b1;
         waited++;
         if (waited > WAIT_LIMIT) report_failure("desc_ready stayed low, descriptor push stalled");
         @(posedge clk);
      end
      exp_src.push_back(src);
      exp_dst.push_back(dst);
      exp_len.push_back(len);
      #1;
      desc_valid = 1'b0;
   endtask

   // ****************************************
   // Source memory model
   // ****************************************
   initial begin : read_memory
      int        waited;
      t_dma_addr addr;
      t_dma_len  len;
      for (int burst = 0; burst < NUM_DESC; burst++) begin
         waited = 0;
         @(posedge clk);
         while (!(ar_valid && ar_ready)) begin
            waited++;
            if (waited > WAIT_LIMIT) report_failure("no read address handshake arrived");
            #1;
            ar_ready = 1'($random(seed));
            @(posedge clk);
         end
         addr = ar_addr;
         len  = ar_len;
         if (burst >= exp_src.size()) begin
            report_failure("read burst issued with no descriptor pushed");
         end
         check_addr($sformatf("ar_addr burst %0d", burst), exp_src[burst], addr);
         check_len($sformatf("ar_len burst %0d", burst), exp_len[burst], len);
         #1;
         ar_ready = 1'b0;
         for (int k = 0; k <= int'(len); k++) begin
            repeat ($random(seed) & 3) begin
               @(posedge clk);
               #1;
            end
            r_valid = 1'b1;
            r_data  = source_word(addr + k);
            r_last  = (k == int'(len));
            waited  = 0;
            @(posedge clk);
            while (!r_ready) begin
               waited++;
               if (waited > WAIT_LIMIT) report_failure("r_ready stayed low, read data stalled");
               @(posedge clk);
            end
            #1;
            r_valid = 1'b0;
            r_last  = 1'b0;
         end
      end
   end

   // ****************************************
   // Destination memory model
   // ****************************************
   initial begin : write_memory
      int        waited;
      int        k;
      t_dma_addr src;
      t_dma_len  len;
      for (int burst = 0; burst < NUM_DESC; burst++) begin
         waited = 0;
         @(posedge clk);
         while (!(aw_valid && aw_ready)) begin
            waited++;
            if (waited > WAIT_LIMIT) report_failure("no write address handshake arrived");
            #1;
            aw_ready = 1'($random(seed));
            @(posedge clk);
         end
         if (burst >= exp_dst.size()) begin
            report_failure("write burst issued with no descriptor pushed");
         end
         check_addr($sformatf("aw_addr burst %0d", burst), exp_dst[burst], aw_addr);
         check_len($sformatf("aw_len burst %0d", burst), exp_len[burst], aw_len);
         src = exp_src[burst];
         len = exp_len[burst];
         #1;
         aw_ready = 1'b0;
         if (len == 8'd15) begin                  // Writes held off until the data FIFO fills.
            waited = 0;
            @(posedge clk);
            while (!(r_valid && !r_ready)) begin
               waited++;
               if (waited > WAIT_LIMIT) begin
                  report_failure("r_ready never dropped while the data FIFO was full");
               end
               @(posedge clk);
            end
            #1;
         end
         k        = 0;
         waited   = 0;
         while (k <= int'(len)) begin
            w_ready = 1'($random(seed));   // Slow writes back up the data FIFO.
            @(posedge clk);
            if (w_valid && w_ready) begin
               check_data($sformatf("w_data burst %0d beat %0d", burst, k),
                          source_word(src + k), w_data);
               check_flag($sformatf("w_last burst %0d beat %0d", burst, k),
                          k == int'(len), w_last);
               k++;
               waited = 0;
            end else begin
               waited++;
               if (waited > WAIT_LIMIT) report_failure("write data beats stopped arriving");
            end
            #1;
         end
         w_ready = 1'b0;
         repeat ($random(seed) & 7) begin
            @(posedge clk);
            #1;
         end
         b_valid = 1'b1;
         waited  = 0;
         @(posedge clk);
         while (!b_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) report_failure("b_ready stayed low, write response stalled");
            @(posedge clk);
         end
         #1;
         b_count++;
         b_valid = 1'b0;
      end
   end

   // Each done pulse must follow its own write response.
   always @(posedge clk) begin
      if (reset_n && done) begin
         if (done_count >= b_count) begin
            report_failure("done pulsed without a matching write response");
         end
         done_count++;
      end
   end

   // ****************************************
   // Main sequence
   // ****************************************
   initial begin : main_sequence
      int       waited;
      t_dma_len len;
      seed          = 32'h431a;
      reset_n       = 1'b0;
      desc_valid    = 1'b0;
      desc_src_addr = '0;
      desc_dst_addr = '0;
      desc_len      = '0;
      ar_ready      = 1'b0;
      r_valid       = 1'b0;
      r_data        = '0;
      r_last        = 1'b0;
      aw_ready      = 1'b0;
      w_ready       = 1'b0;
      b_valid       = 1'b0;
      b_count       = 0;
      done_count    = 0;
      saw_full      = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      reset_n = 1'b1;

      repeat (6) begin                                // Idle engine after reset.
         @(posedge clk);
         check_flag("idle ar_valid", 1'b0, ar_valid);
         check_flag("idle r_ready", 1'b0, r_ready);
         check_flag("idle aw_valid", 1'b0, aw_valid);
         check_flag("idle w_valid", 1'b0, w_valid);
         check_flag("idle b_ready", 1'b0, b_ready);
         check_flag("idle done", 1'b0, done);
         check_flag("idle desc_ready", 1'b1, desc_ready);
      end
      #1;

      for (int i = 0; i < NUM_DESC; i++) begin
         if (i >= 8) begin                            // The first eight go back to back.
            repeat ($random(seed) & 3) begin
               @(posedge clk);
               #1;
            end
         end
         if (i == 0) begin
            len = 8'd15;                              // At least one burst overfills the data FIFO.
         end else begin
            case ($random(seed) & 3)
               0:       len = '0;
               1:       len = 8'd15;                  // Longer than the data FIFO.
               default: len = t_dma_len'($random(seed) & 15);
            endcase
         end
         push_descriptor($random(seed), $random(seed), len);
      end

      waited = 0;
      while (done_count < NUM_DESC) begin
         waited++;
         if (waited > WAIT_LIMIT * 4) report_failure("engine stopped before all copies finished");
         @(posedge clk);
      end
      repeat (10) @(posedge clk);
      check_count("done pulses", NUM_DESC, done_count);
      check_count("write responses", NUM_DESC, b_count);
      if (!saw_full) begin
         report_failure("desc_ready never dropped during back to back pushes");
      end else begin
         $display("All checks passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- dma_engine.f
+incdir+logic
logic/dma_pkg.sv
logic/dma_descriptor_fifo.sv
logic/dma_read_fsm.sv
logic/dma_data_fifo.sv
logic/dma_write_fsm.sv
logic/dma_engine.sv
verification/dma_engine_tb.sv

//--- Bender.yml
package:
  name: dma_engine

export_include_dirs:
  - logic

sources:
  - files:
      - logic/dma_pkg.sv
      - logic/dma_descriptor_fifo.sv
      - logic/dma_read_fsm.sv
      - logic/dma_data_fifo.sv
      - logic/dma_write_fsm.sv
      - logic/dma_engine.sv
  - target: simulation
    files:
      - verification/dma_engine_tb.sv
